// ==== include/eth_cfg.svh ====
`ifndef ETH_CFG_SVH
`define ETH_CFG_SVH

// smi address of the phy on the management bus
`define ETH_PHY_ADDR 5'd1

// register that is polled
// phy-specific status register
`define ETH_STATUS_REG 5'd17

// speed field inside the status word
// 2'b10 gigabit, 2'b01 100 mbps, 2'b00 10 mbps
`define ETH_SPEED_MSB 15
`define ETH_SPEED_LSB 14

// link up flag inside the status word
`define ETH_LINK_BIT 10

// clk cycles per mdc half period
// keep at 2 or more so the two strobes never land in adjacent cycles
`define ETH_MDC_HALF 4

`endif

// ==== hw/eth_pkg.sv ====
package eth_pkg;

    // link speed code from the phy status register
    typedef logic [1:0] eth_speed_t;

    // gigabit code, selects the byte-wide path in the adapter
    localparam eth_speed_t SPEED_1G = 2'b10;

    // mac side data unit
    typedef logic [7:0] eth_byte_t;

    // 10/100 data unit on the phy lines
    typedef logic [3:0] eth_nibble_t;

    // register data carried by an mdio frame
    typedef logic [15:0] mdio_word_t;

    // address fields of the read command
    typedef logic [4:0] phy_addr_t;
    typedef logic [4:0] reg_addr_t;

    // smi master states
    // one pass through PRE..DATA is one read frame
    typedef enum logic [2:0] {
        SMI_IDLE,
        SMI_PRE,
        SMI_CMD,
        SMI_TA,
        SMI_DATA,
        SMI_DONE
    } smi_state_t;

endpackage

// ==== hw/mdc_timer.sv ====
`include "eth_cfg.svh"

module mdc_timer (
    input  logic clk,
    input  logic arst_n,
    output logic mdc,
    output logic mdc_rise,
    output logic mdc_fall
);

    // counter width for one half period
    localparam int CNT_W = $clog2(`ETH_MDC_HALF);

    // last count of a half period
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`ETH_MDC_HALF - 1);

    logic [CNT_W-1:0] cnt;

    // free running divider
    // strobes are registered alongside mdc, so each one is
    // high in exactly the clk cycle where mdc takes its new level
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            mdc      <= 1'b0;
            mdc_rise <= 1'b0;
            mdc_fall <= 1'b0;
        end else begin
            // strobes last one cycle only
            mdc_rise <= 1'b0;
            mdc_fall <= 1'b0;
            if (cnt == CNT_LAST) begin
                cnt <= '0;
                mdc <= ~mdc;
                // low going high
                mdc_rise <= ~mdc;
                // high going low
                mdc_fall <= mdc;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/smi_fsm.sv ====
`include "eth_cfg.svh"

module smi_fsm
    import eth_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       mdc_rise,
    input  logic       mdc_fall,
    input  logic       mdio_i,
    output logic       mdio_o,
    output logic       mdio_oe,
    output logic       link,
    output eth_speed_t speed
);

    localparam phy_addr_t PHY_ADDR   = `ETH_PHY_ADDR;
    localparam reg_addr_t STATUS_REG = `ETH_STATUS_REG;

    // start 01, read opcode 10, then both addresses msb first
    localparam logic [13:0] CMD_WORD = {2'b01, 2'b10, PHY_ADDR, STATUS_REG};

    smi_state_t state;

    // bits left in the current phase, 0 on its last bit
    // in idle it counts the mdc periods still to wait
    logic [4:0] bit_cnt;

    // outgoing command bits, msb drives the line
    logic [13:0] cmd_sr;

    // incoming register data, msb arrives first
    mdio_word_t data_sr;

    logic cmd_shift;

    // a command bit leaves on the last preamble fall and on every
    // command fall except the one that ends the phase
    assign cmd_shift = mdc_fall &&
                       (((state == SMI_PRE) && (bit_cnt == 5'd0)) ||
                        ((state == SMI_CMD) && (bit_cnt != 5'd0)));

    // phases advance on mdc_fall so the line settles while mdc is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= SMI_IDLE;
            bit_cnt <= 5'd0;
            mdio_o  <= 1'b0;
            mdio_oe <= 1'b0;
            link    <= 1'b0;
            speed   <= 2'b00;
        end else begin
            unique case (state)
                SMI_IDLE: begin
                    if (mdc_fall) begin
                        if (bit_cnt == 5'd0) begin
                            // first preamble bit
                            state   <= SMI_PRE;
                            bit_cnt <= 5'd31;
                            mdio_o  <= 1'b1;
                            mdio_oe <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt - 5'd1;
                        end
                    end
                end
                SMI_PRE: begin
                    if (mdc_fall) begin
                        if (bit_cnt == 5'd0) begin
                            // start bit 0 goes out first
                            state   <= SMI_CMD;
                            bit_cnt <= 5'd13;
                            mdio_o  <= cmd_sr[13];
                        end else begin
                            // line stays high
                            bit_cnt <= bit_cnt - 5'd1;
                        end
                    end
                end
                SMI_CMD: begin
                    if (mdc_fall) begin
                        if (bit_cnt == 5'd0) begin
                            // release the bus for turnaround
                            state   <= SMI_TA;
                            bit_cnt <= 5'd1;
                            mdio_o  <= 1'b0;
                            mdio_oe <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt - 5'd1;
                            mdio_o  <= cmd_sr[13];
                        end
                    end
                end
                SMI_TA: begin
                    // two released bits, nothing sampled
                    if (mdc_fall) begin
                        if (bit_cnt == 5'd0) begin
                            state   <= SMI_DATA;
                            bit_cnt <= 5'd15;
                        end else begin
                            bit_cnt <= bit_cnt - 5'd1;
                        end
                    end
                end
                SMI_DATA: begin
                    // the rise inside the last bit period ends the read
                    if (mdc_rise && (bit_cnt == 5'd0)) begin
                        state <= SMI_DONE;
                    end else if (mdc_fall) begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                SMI_DONE: begin
                    // word is complete here, one clk after the last sample
                    link  <= data_sr[`ETH_LINK_BIT];
                    speed <= data_sr[`ETH_SPEED_MSB:`ETH_SPEED_LSB];
                    state <= SMI_IDLE;
                    // skip the fall that closes the last data bit,
                    // then one full idle mdc period
                    bit_cnt <= 5'd1;
                end
                default: begin
                    state   <= SMI_IDLE;
                    bit_cnt <= 5'd0;
                    mdio_oe <= 1'b0;
                end
            endcase
        end
    end

    // command and data shifters
    always_ff @(posedge clk) begin
        if (state == SMI_IDLE) begin
            cmd_sr <= CMD_WORD;
        end else if (cmd_shift) begin
            cmd_sr <= {cmd_sr[12:0], 1'b0};
        end
        // phy drives the bit while mdc is low, sample on the rise
        if ((state == SMI_DATA) && mdc_rise) begin
            data_sr <= {data_sr[14:0], mdio_i};
        end
    end

endmodule

// ==== hw/gmii_arbi.sv ====
module gmii_arbi
    import eth_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  eth_speed_t speed,
    input  logic       link,
    input  logic       mac_txen,
    input  eth_byte_t  mac_txd,
    output logic       phy_txen,
    output eth_byte_t  phy_txd,
    input  logic       phy_rxdv,
    input  eth_byte_t  phy_rxd,
    output logic       mac_rxdv,
    output eth_byte_t  mac_rxd
);

    // transmit side
    eth_speed_t  tx_speed_q;
    eth_speed_t  tx_speed;
    logic        tx_gig;
    logic        tx_en_q;
    // high nibble still to send
    logic        tx_phase;
    eth_nibble_t tx_hi;

    // receive side
    eth_speed_t  rx_speed_q;
    eth_speed_t  rx_speed;
    logic        rx_gig;
    // phy_rxdv of the previous cycle
    logic        rx_busy;
    logic        rx_dv_q;
    // low nibble already held
    logic        rx_phase;
    eth_nibble_t rx_nib;

    // speed is taken fresh only between bursts
    // a burst keeps the mode it started with
    assign tx_speed = tx_en_q ? tx_speed_q : speed;
    assign rx_speed = rx_busy ? rx_speed_q : speed;
    assign tx_gig   = (tx_speed == SPEED_1G);
    assign rx_gig   = (rx_speed == SPEED_1G);

    // link down cuts both valids at once
    assign phy_txen = tx_en_q & link;
    assign mac_rxdv = rx_dv_q & link;

    // tx control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_speed_q <= 2'b00;
            tx_en_q    <= 1'b0;
            tx_phase   <= 1'b0;
        end else begin
            tx_speed_q <= tx_speed;
            if (!link) begin
                tx_en_q  <= 1'b0;
                tx_phase <= 1'b0;
            end else if (tx_gig) begin
                // straight register stage
                tx_en_q  <= mac_txen;
                tx_phase <= 1'b0;
            end else if (tx_phase) begin
                // second nibble of the held byte
                tx_en_q  <= 1'b1;
                tx_phase <= 1'b0;
            end else begin
                tx_en_q  <= mac_txen;
                tx_phase <= mac_txen;
            end
        end
    end

    // tx data, low nibble first at 10/100
    always_ff @(posedge clk) begin
        if (tx_gig) begin
            phy_txd <= mac_txd;
        end else if (tx_phase) begin
            phy_txd <= {4'h0, tx_hi};
        end else if (mac_txen) begin
            phy_txd <= {4'h0, mac_txd[3:0]};
            tx_hi   <= mac_txd[7:4];
        end
    end

    // rx control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_speed_q <= 2'b00;
            rx_busy    <= 1'b0;
            rx_dv_q    <= 1'b0;
            rx_phase   <= 1'b0;
        end else begin
            rx_speed_q <= rx_speed;
            rx_busy    <= phy_rxdv;
            if (!link || !phy_rxdv) begin
                // an unpaired nibble is dropped here
                rx_dv_q  <= 1'b0;
                rx_phase <= 1'b0;
            end else if (rx_gig) begin
                rx_dv_q  <= 1'b1;
                rx_phase <= 1'b0;
            end else begin
                // strobe after every second nibble
                rx_dv_q  <= rx_phase;
                rx_phase <= ~rx_phase;
            end
        end
    end

    // rx data, pack nibble pairs
    always_ff @(posedge clk) begin
        if (phy_rxdv) begin
            if (rx_gig) begin
                mac_rxd <= phy_rxd;
            end else if (rx_phase) begin
                mac_rxd <= {phy_rxd[3:0], rx_nib};
            end else begin
                rx_nib <= phy_rxd[3:0];
            end
        end
    end

endmodule

// ==== hw/eth.sv ====
module eth
    import eth_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    // management bus
    output logic       mdc,
    output logic       mdio_o,
    output logic       mdio_oe,
    input  logic       mdio_i,
    // link state from the status poll
    output logic       link,
    output eth_speed_t speed,
    // mac side
    input  logic       mac_txen,
    input  eth_byte_t  mac_txd,
    output logic       mac_rxdv,
    output eth_byte_t  mac_rxd,
    // phy side, single data rate
    output logic       phy_txen,
    output eth_byte_t  phy_txd,
    input  logic       phy_rxdv,
    input  eth_byte_t  phy_rxd
);

    logic mdc_rise;
    logic mdc_fall;

    // mdc generation
    mdc_timer u_mdc_timer (
        .clk      (clk),
        .arst_n   (arst_n),
        .mdc      (mdc),
        .mdc_rise (mdc_rise),
        .mdc_fall (mdc_fall)
    );

    // status register polling
    smi_fsm u_smi_fsm (
        .clk      (clk),
        .arst_n   (arst_n),
        .mdc_rise (mdc_rise),
        .mdc_fall (mdc_fall),
        .mdio_i   (mdio_i),
        .mdio_o   (mdio_o),
        .mdio_oe  (mdio_oe),
        .link     (link),
        .speed    (speed)
    );

    // byte or nibble adaptation, follows the polled speed
    gmii_arbi u_gmii_arbi (
        .clk      (clk),
        .arst_n   (arst_n),
        .speed    (speed),
        .link     (link),
        .mac_txen (mac_txen),
        .mac_txd  (mac_txd),
        .phy_txen (phy_txen),
        .phy_txd  (phy_txd),
        .phy_rxdv (phy_rxdv),
        .phy_rxd  (phy_rxd),
        .mac_rxdv (mac_rxdv),
        .mac_rxd  (mac_rxd)
    );

endmodule

// ==== verification/eth_asserts.sv ====
module eth_asserts
    import eth_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       mdc,
    input logic       mdio_o,
    input logic       mdio_oe,
    input logic       link,
    input eth_speed_t speed,
    input logic       mac_txen,
    input eth_byte_t  mac_txd,
    input logic       mac_rxdv,
    input eth_byte_t  mac_rxd,
    input logic       phy_txen,
    input eth_byte_t  phy_txd,
    input logic       phy_rxdv,
    input eth_byte_t  phy_rxd
);

    timeunit 1ns;
    timeprecision 1ps;

    logic idle_outs;

    assign idle_outs = !mdc && !mdio_oe && !link && (speed == 2'b00) && !phy_txen && !mac_rxdv;

    // held in reset and in the first cycle after release
    a_rst_hold: assert property (@(posedge clk) !arst_n |-> idle_outs)
        else $error("outputs left reset values during reset");
    a_rst_release: assert property (@(posedge clk) !arst_n |=> idle_outs)
        else $error("outputs left reset values right after release");

    // mdio lines only move while mdc is low
    a_oe_mdc_low: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(mdio_oe) |-> !mdc) else $error("mdio_oe moved while mdc high");
    a_o_mdc_low: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(mdio_o) |-> !mdc) else $error("mdio_o moved while mdc high");
    // a frame opens with a preamble one
    a_pre_start: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(mdio_oe) |-> mdio_o) else $error("frame did not start with a one");

    // gigabit paths are one register stage
    a_gig_tx: assert property (@(posedge clk) disable iff (!arst_n)
        (link && speed == SPEED_1G) |=> (!link || (phy_txen == $past(mac_txen) &&
        (!phy_txen || phy_txd == $past(mac_txd))))) else $error("gigabit tx mismatch");
    a_gig_rx: assert property (@(posedge clk) disable iff (!arst_n)
        (link && speed == SPEED_1G) |=> (!link || (mac_rxdv == $past(phy_rxdv) &&
        (!mac_rxdv || mac_rxd == $past(phy_rxd))))) else $error("gigabit rx mismatch");

    // 10/100 timing rules
    a_nib_spacing: assert property (@(posedge clk) disable iff (!arst_n)
        (link && speed != SPEED_1G && mac_txen) |=> !mac_txen)
        else $error("mac_txen strobes closer than two cycles");
    a_nib_upper: assert property (@(posedge clk) disable iff (!arst_n)
        (phy_txen && speed != SPEED_1G && $stable(speed)) |-> (phy_txd[7:4] == 4'h0))
        else $error("upper tx lines not zero at 10/100");
    a_nib_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        (mac_rxdv && speed != SPEED_1G && $stable(speed)) |=> !mac_rxdv)
        else $error("mac_rxdv longer than one cycle at 10/100");

endmodule

bind eth eth_asserts u_eth_asserts (.*);

// ==== verification/eth_tb.sv ====
`include "eth_cfg.svh"

module eth_tb
    import eth_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYCLES    = 64 * 2 * `ETH_MDC_HALF;
    localparam int WATCHDOG_CYCLES = 6 * FRAME_CYCLES + 2000;
    // preamble, start, read opcode, phy address, register address
    localparam logic [45:0] DRIVE_BITS =
        {32'hffff_ffff, 2'b01, 2'b10, 5'(`ETH_PHY_ADDR), 5'(`ETH_STATUS_REG)};

    logic       clk = 1'b0;
    logic       arst_n;
    logic       mdc;
    logic       mdio_o;
    logic       mdio_oe;
    logic       mdio_i = 1'b0;
    logic       link;
    eth_speed_t speed;
    logic       mac_txen;
    eth_byte_t  mac_txd;
    logic       mac_rxdv;
    eth_byte_t  mac_rxd;
    logic       phy_txen;
    eth_byte_t  phy_txd;
    logic       phy_rxdv;
    eth_byte_t  phy_rxd;

    // phy model state
    logic        mdc_q;
    logic        in_frame;
    int          rise_idx;
    int          idle_rises;
    int          frame_starts = 0;
    logic [45:0] drive_sr;
    mdio_word_t  resp_sr;
    mdio_word_t  last_word;

    // expected bytes at gigabit
    eth_byte_t tx_q[$];
    eth_byte_t rx_q[$];

    eth u_eth (.*);

    always #5 clk = ~clk;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // frames 0..2 link up at 1g, 100, 10; later frames link down
    function automatic mdio_word_t make_word(input int f);
        mdio_word_t w;
        w = 16'($urandom);
        w[`ETH_LINK_BIT] = (f < 3);
        if (f < 3) begin
            w[`ETH_SPEED_MSB:`ETH_SPEED_LSB] = 2'(2 - f);
        end
        return w;
    endfunction

    // status of the previous frame must be visible at the next preamble
    task automatic check_status();
        logic       exp_link;
        eth_speed_t exp_speed;
        exp_link  = (frame_starts == 0) ? 1'b0 : last_word[`ETH_LINK_BIT];
        exp_speed = (frame_starts == 0) ? 2'b00 : last_word[`ETH_SPEED_MSB:`ETH_SPEED_LSB];
        check_val("link", 16'(exp_link), 16'(link));
        check_val("speed", 16'(exp_speed), 16'(speed));
    endtask

    task automatic check_frame_bit();
        if (rise_idx < 46) begin
            check_val("mdio_oe", 16'h1, 16'(mdio_oe));
            check_val("mdio_o", 16'(drive_sr[45]), 16'(mdio_o));
            drive_sr = drive_sr << 1;
        end else begin
            // turnaround and data, bus released
            check_val("mdio_oe", 16'h0, 16'(mdio_oe));
        end
    endtask

    task automatic decode_rise();
        if (!in_frame && !mdio_oe) begin
            idle_rises++;
        end else if (!in_frame) begin
            if (idle_rises != 1) begin
                fail_now("mdio frame did not follow exactly one idle mdc period");
            end
            check_status();
            last_word    = make_word(frame_starts);
            resp_sr      = last_word;
            drive_sr     = DRIVE_BITS;
            in_frame     = 1'b1;
            rise_idx     = 0;
            frame_starts = frame_starts + 1;
            check_frame_bit();
        end else begin
            rise_idx++;
            check_frame_bit();
            if (rise_idx == 63) begin
                in_frame   = 1'b0;
                idle_rises = 0;
            end
        end
    endtask

    // phy model, sees mdc edges from the falling clk edge
    always @(negedge clk) begin
        if (!arst_n) begin
            mdc_q      = 1'b0;
            in_frame   = 1'b0;
            rise_idx   = 0;
            idle_rises = 0;
            mdio_i     = 1'b0;
        end else begin
            if (mdc && !mdc_q) begin
                decode_rise();
            end else if (!mdc && mdc_q) begin
                // data bit goes out while mdc is low, msb first
                if (in_frame && rise_idx >= 47 && rise_idx <= 62) begin
                    mdio_i  = resp_sr[15];
                    resp_sr = resp_sr << 1;
                end else begin
                    mdio_i = 1'b0;
                end
            end
            mdc_q = mdc;
        end
    end

    // tx and rx bursts side by side, each one cycle through
    task automatic gig_burst(input int n);
        eth_byte_t b;
        for (int i = 0; i <= n; i++) begin
            if (i > 0) begin
                check_val("phy_txen", 16'h1, 16'(phy_txen));
                check_val("phy_txd", 16'(tx_q.pop_front()), 16'(phy_txd));
                check_val("mac_rxdv", 16'h1, 16'(mac_rxdv));
                check_val("mac_rxd", 16'(rx_q.pop_front()), 16'(mac_rxd));
            end
            mac_txen = (i < n);
            phy_rxdv = (i < n);
            b = 8'($urandom);
            mac_txd = b;
            tx_q.push_back(b);
            b = 8'($urandom);
            phy_rxd = b;
            rx_q.push_back(b);
            @(negedge clk);
        end
        check_val("phy_txen", 16'h0, 16'(phy_txen));
        check_val("mac_rxdv", 16'h0, 16'(mac_rxdv));
        tx_q.delete();
        rx_q.delete();
    endtask

    task automatic nibble_tx_burst(input int n);
        eth_byte_t b;
        for (int i = 0; i < n; i++) begin
            b        = 8'($urandom);
            mac_txen = 1'b1;
            mac_txd  = b;
            @(negedge clk);
            mac_txen = 1'b0;
            mac_txd  = 8'($urandom);
            check_val("phy_txen", 16'h1, 16'(phy_txen));
            check_val("phy_txd", 16'({4'h0, b[3:0]}), 16'(phy_txd));
            @(negedge clk);
            check_val("phy_txen", 16'h1, 16'(phy_txen));
            check_val("phy_txd", 16'({4'h0, b[7:4]}), 16'(phy_txd));
        end
        @(negedge clk);
        check_val("phy_txen", 16'h0, 16'(phy_txen));
    endtask

    // n nibble pairs, then one odd nibble that must vanish
    task automatic nibble_rx_burst(input int n);
        eth_byte_t lo;
        eth_byte_t hi;
        phy_rxdv = 1'b1;
        for (int i = 0; i < n; i++) begin
            lo      = 8'($urandom);
            phy_rxd = lo;
            @(negedge clk);
            check_val("mac_rxdv", 16'h0, 16'(mac_rxdv));
            hi      = 8'($urandom);
            phy_rxd = hi;
            @(negedge clk);
            check_val("mac_rxdv", 16'h1, 16'(mac_rxdv));
            check_val("mac_rxd", 16'({hi[3:0], lo[3:0]}), 16'(mac_rxd));
        end
        phy_rxd = 8'($urandom);
        @(negedge clk);
        phy_rxdv = 1'b0;
        repeat (2) begin
            check_val("mac_rxdv", 16'h0, 16'(mac_rxdv));
            @(negedge clk);
        end
    endtask

    // traffic on both sides while link is down
    task automatic link_gate_burst(input int n);
        for (int i = 0; i < n; i++) begin
            mac_txen = (i % 2 == 0);
            mac_txd  = 8'($urandom);
            phy_rxdv = 1'b1;
            phy_rxd  = 8'($urandom);
            @(negedge clk);
            check_val("phy_txen", 16'h0, 16'(phy_txen));
            check_val("mac_rxdv", 16'h0, 16'(mac_rxdv));
        end
        mac_txen = 1'b0;
        phy_rxdv = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before all steps were done");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h46ca_ebaf));
        arst_n   = 1'b0;
        mac_txen = 1'b0;
        mac_txd  = '0;
        phy_rxdv = 1'b0;
        phy_rxd  = '0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        // frame 0 word in effect once frame 1 starts, gigabit link up
        wait (frame_starts >= 2);
        @(negedge clk);
        gig_burst(8);
        // 100 mbps from frame 1
        wait (frame_starts >= 3);
        @(negedge clk);
        nibble_tx_burst(6);
        nibble_rx_burst(4);
        nibble_rx_burst(3);
        // frame 3 answers link down, seen from frame 4 on
        wait (frame_starts >= 5);
        @(negedge clk);
        link_gate_burst(12);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
hw/eth_pkg.sv
hw/mdc_timer.sv
hw/smi_fsm.sv
hw/gmii_arbi.sv
hw/eth.sv
verification/eth_asserts.sv
verification/eth_tb.sv

// ==== Makefile ====
TOP := eth_tb
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Iinclude hw/eth_pkg.sv hw/mdc_timer.sv hw/smi_fsm.sv \
		hw/gmii_arbi.sv hw/eth.sv --top-module eth
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		--Mdir $(OBJ) -o $(TOP)
	./$(OBJ)/$(TOP)

clean:
	rm -rf $(OBJ)
